/* source/aluPkg.sv */
package aluPkg;

  // ====================
  // Data path widths
  // ====================

  localparam int dataWidth  = 32;
  localparam int shamtWidth = 5;
  localparam int aluOpWidth = 5;

  // ====================
  // ALU operation codes
  // ====================

  // The low three bits follow funct3 and bit 3 follows funct7[5].
  // Bit 4 set marks an operation that drives only the flag.
  typedef enum logic [aluOpWidth-1:0]
  {
    aluAdd  = 5'b00000,
    aluSll  = 5'b00001,
    aluSlts = 5'b00010,
    aluSltu = 5'b00011,
    aluXor  = 5'b00100,
    aluSrl  = 5'b00101,
    aluOr   = 5'b00110,
    aluAnd  = 5'b00111,
    aluSub  = 5'b01000,
    aluSra  = 5'b01101,
    aluEq   = 5'b11000,  // Branch compares.
    aluNe   = 5'b11001,
    aluLts  = 5'b11100,
    aluGes  = 5'b11101,
    aluLtu  = 5'b11110,
    aluGeu  = 5'b11111
  } aluOp_t;

endpackage

/* source/riscvPkg.sv */
package riscvPkg;

  // ====================
  // Constants
  // ====================

  localparam int regCount     = 32;
  localparam int regAddrWidth = 5;

  localparam logic [aluPkg::dataWidth-1:0] resetPc = '0;
  localparam logic [aluPkg::dataWidth-1:0] pcStep  = 32'd4;

  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;

  // ====================
  // Instruction formats
  // ====================

  typedef union packed
  {
    struct packed
    {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rType;
    struct packed
    {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } iType;
    struct packed
    {
      logic       imm12;
      logic [5:0] imm10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4to1;
      logic       imm11;
      logic [6:0] opcode;
    } bType;
    struct packed
    {
      logic [19:0] imm;  // Bits 31:12 of the value.
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } uType;
    struct packed
    {
      logic       imm20;
      logic [9:0] imm10to1;
      logic       imm11;
      logic [7:0] imm19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } jType;
  } instr_t;

  // ====================
  // Control and write-back
  // ====================

  typedef enum logic [1:0]
  {
    aRs1  = 2'd0,
    aPc   = 2'd1,
    aZero = 2'd2
  } aSel_t;

  typedef enum logic [1:0]
  {
    pcNext   = 2'd0,
    pcBranch = 2'd1,
    pcJal    = 2'd2,
    pcJalr   = 2'd3
  } pcSel_t;

  typedef struct packed
  {
    aluPkg::aluOp_t          aluOp;
    aSel_t                   aSel;
    logic                    bImm;      // Immediate as operand B.
    logic                    regWrite;
    logic                    wbLink;    // Write PC+4.
    pcSel_t                  pcSel;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
  } ctrl_t;

  // Retires as a no-operation.
  localparam ctrl_t ctrlNop = '{
    aluOp:    aluPkg::aluAdd,
    aSel:     aRs1,
    bImm:     1'b0,
    regWrite: 1'b0,
    wbLink:   1'b0,
    pcSel:    pcNext,
    rd:       '0,
    rs1:      '0,
    rs2:      '0
  };

  typedef struct packed
  {
    logic                         enable;
    logic [regAddrWidth-1:0]      rd;
    logic [aluPkg::dataWidth-1:0] data;
  } writeBack_t;

endpackage

/* source/aluRiscv.sv */
module aluRiscv
(
  input  aluPkg::aluOp_t               aluOp,
  input  logic [aluPkg::dataWidth-1:0] a,
  input  logic [aluPkg::dataWidth-1:0] b,
  output logic [aluPkg::dataWidth-1:0] result,
  output logic                         flag
);

  logic [aluPkg::shamtWidth-1:0] shamt;

  assign shamt = b[aluPkg::shamtWidth-1:0];  // RV32I shifts by 5 bits.

  always_comb
  begin
    result = '0;
    flag   = 1'b0;

    case (aluOp)
      // ====================
      // Result operations
      // ====================
      aluPkg::aluAdd:  result = a + b;
      aluPkg::aluSub:  result = a - b;
      aluPkg::aluSll:  result = a << shamt;
      aluPkg::aluSlts: result = {{(aluPkg::dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
      aluPkg::aluSltu: result = {{(aluPkg::dataWidth-1){1'b0}}, a < b};
      aluPkg::aluXor:  result = a ^ b;
      aluPkg::aluSrl:  result = a >> shamt;
      aluPkg::aluSra:  result = $signed(a) >>> shamt;
      aluPkg::aluOr:   result = a | b;
      aluPkg::aluAnd:  result = a & b;

      // ====================
      // Flag operations
      // ====================
      aluPkg::aluEq:   flag = (a == b);
      aluPkg::aluNe:   flag = (a != b);
      aluPkg::aluLts:  flag = $signed(a) < $signed(b);
      aluPkg::aluGes:  flag = $signed(a) >= $signed(b);
      aluPkg::aluLtu:  flag = a < b;
      aluPkg::aluGeu:  flag = a >= b;

      default:
      begin
        result = '0;  // Unknown code gives zeros.
        flag   = 1'b0;
      end
    endcase
  end

endmodule

/* source/instrDecoder.sv */
module instrDecoder
(
  input  riscvPkg::instr_t             instr,
  output riscvPkg::ctrl_t              ctrl,
  output logic [aluPkg::dataWidth-1:0] imm
);

  logic [2:0] funct3;
  logic       funct7Alt;
  logic       altOp;

  assign funct3    = instr.rType.funct3;
  assign funct7Alt = instr.rType.funct7[5];

  always_comb
  begin
    ctrl  = riscvPkg::ctrlNop;
    imm   = '0;
    altOp = 1'b0;

    case (instr.rType.opcode)
      // ====================
      // ALU groups
      // ====================
      riscvPkg::opOp:
      begin
        altOp          = funct7Alt & ((funct3 == 3'b000) || (funct3 == 3'b101));  // SUB, SRA.
        ctrl.aluOp     = aluPkg::aluOp_t'({1'b0, altOp, funct3});
        ctrl.regWrite  = 1'b1;
        ctrl.rd        = instr.rType.rd;
        ctrl.rs1       = instr.rType.rs1;
        ctrl.rs2       = instr.rType.rs2;
      end

      riscvPkg::opOpImm:
      begin
        imm            = {{20{instr.iType.imm[11]}}, instr.iType.imm};
        altOp          = funct7Alt & (funct3 == 3'b101);  // Only SRAI.
        ctrl.aluOp     = aluPkg::aluOp_t'({1'b0, altOp, funct3});
        ctrl.bImm      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.rd        = instr.iType.rd;
        ctrl.rs1       = instr.iType.rs1;
      end

      // ====================
      // Upper immediates
      // ====================
      riscvPkg::opLui:
      begin
        imm            = {instr.uType.imm, 12'b0};
        ctrl.aSel      = riscvPkg::aZero;
        ctrl.bImm      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.rd        = instr.uType.rd;
      end

      riscvPkg::opAuipc:
      begin
        imm            = {instr.uType.imm, 12'b0};
        ctrl.aSel      = riscvPkg::aPc;
        ctrl.bImm      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.rd        = instr.uType.rd;
      end

      // ====================
      // Control transfer
      // ====================
      riscvPkg::opJal:
      begin
        imm            = {{12{instr.jType.imm20}}, instr.jType.imm19to12,
                          instr.jType.imm11, instr.jType.imm10to1, 1'b0};
        ctrl.regWrite  = 1'b1;
        ctrl.wbLink    = 1'b1;
        ctrl.pcSel     = riscvPkg::pcJal;
        ctrl.rd        = instr.jType.rd;
      end

      riscvPkg::opJalr:
      begin
        imm            = {{20{instr.iType.imm[11]}}, instr.iType.imm};
        ctrl.bImm      = 1'b1;  // ALU forms rs1+imm.
        ctrl.regWrite  = 1'b1;
        ctrl.wbLink    = 1'b1;
        ctrl.pcSel     = riscvPkg::pcJalr;
        ctrl.rd        = instr.iType.rd;
        ctrl.rs1       = instr.iType.rs1;
      end

      riscvPkg::opBranch:
      begin
        imm            = {{20{instr.bType.imm12}}, instr.bType.imm11,
                          instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
        ctrl.aluOp     = aluPkg::aluOp_t'({2'b11, funct3});  // Compare on the flag.
        ctrl.pcSel     = riscvPkg::pcBranch;
        ctrl.rs1       = instr.bType.rs1;
        ctrl.rs2       = instr.bType.rs2;
      end

      default:
      begin
        ctrl = riscvPkg::ctrlNop;  // Unsupported opcode.
      end
    endcase
  end

endmodule

/* source/registerFile.sv */
module registerFile
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [riscvPkg::regAddrWidth-1:0]     rs1,
  input  logic [riscvPkg::regAddrWidth-1:0]     rs2,
  output logic [aluPkg::dataWidth-1:0]          rs1Data,
  output logic [aluPkg::dataWidth-1:0]          rs2Data,
  input  riscvPkg::writeBack_t                  writeBack
);

  logic [aluPkg::dataWidth-1:0] regs [riscvPkg::regCount-1:1];  // No storage for x0.

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 1; i < riscvPkg::regCount; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeBack.enable && (writeBack.rd != '0))
    begin
      regs[writeBack.rd] <= writeBack.data;
    end
  end

  // x0 reads as zero.
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/riscvCore.sv */
module riscvCore
(
  input  logic                         clk,
  input  logic                         reset,
  output logic [aluPkg::dataWidth-1:0] instrAddr,
  input  riscvPkg::instr_t             instr,
  output riscvPkg::writeBack_t         writeBack
);

  riscvPkg::ctrl_t              ctrl;
  logic [aluPkg::dataWidth-1:0] pc;
  logic [aluPkg::dataWidth-1:0] pcPlus4;
  logic [aluPkg::dataWidth-1:0] branchTarget;
  logic [aluPkg::dataWidth-1:0] pcTarget;
  logic [aluPkg::dataWidth-1:0] nextPc;
  logic [aluPkg::dataWidth-1:0] imm;
  logic [aluPkg::dataWidth-1:0] rs1Data;
  logic [aluPkg::dataWidth-1:0] rs2Data;
  logic [aluPkg::dataWidth-1:0] aOperand;
  logic [aluPkg::dataWidth-1:0] bOperand;
  logic [aluPkg::dataWidth-1:0] aluResult;
  logic                         aluFlag;

  // ====================
  // Fetch and PC
  // ====================

  assign instrAddr = pc;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= riscvPkg::resetPc;
    else
      pc <= nextPc;
  end

  assign pcPlus4      = pc + riscvPkg::pcStep;
  assign branchTarget = pc + imm;  // Own adder, not the ALU.

  always_comb
  begin
    case (ctrl.pcSel)
      riscvPkg::pcBranch: pcTarget = aluFlag ? branchTarget : pcPlus4;
      riscvPkg::pcJal:    pcTarget = branchTarget;
      riscvPkg::pcJalr:   pcTarget = aluResult;
      default:            pcTarget = pcPlus4;
    endcase
  end

  assign nextPc = {pcTarget[aluPkg::dataWidth-1:2], 2'b00};  // Word aligned.

  // ====================
  // Decode and execute
  // ====================

  instrDecoder instrDecoder_i
  (
    .instr (instr),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  registerFile registerFile_i
  (
    .clk       (clk),
    .reset     (reset),
    .rs1       (ctrl.rs1),
    .rs2       (ctrl.rs2),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .writeBack (writeBack)
  );

  always_comb
  begin
    case (ctrl.aSel)
      riscvPkg::aRs1: aOperand = rs1Data;
      riscvPkg::aPc:  aOperand = pc;     // AUIPC.
      default:        aOperand = '0;     // LUI.
    endcase
  end

  assign bOperand = ctrl.bImm ? imm : rs2Data;

  aluRiscv aluRiscv_i
  (
    .aluOp  (ctrl.aluOp),
    .a      (aOperand),
    .b      (bOperand),
    .result (aluResult),
    .flag   (aluFlag)
  );

  // ====================
  // Write-back
  // ====================

  assign writeBack.enable = ctrl.regWrite & ~reset;
  assign writeBack.rd     = ctrl.rd;
  assign writeBack.data   = ctrl.wbLink ? pcPlus4 : aluResult;

endmodule

/* verification/riscvRefModel.svh */
`ifndef RISCV_REF_MODEL_SVH
`define RISCV_REF_MODEL_SVH

// ====================
// Architectural state
// ====================

logic [aluPkg::dataWidth-1:0] modelRegs [0:riscvPkg::regCount-1];
logic [aluPkg::dataWidth-1:0] modelPc;

function automatic logic [31:0] readReg(input logic [4:0] idx);
  return (idx == 5'd0) ? 32'd0 : modelRegs[idx];  // x0 is hardwired.
endfunction

function automatic logic [31:0] aluModel(input logic [2:0] funct3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
  logic [31:0] res;
  case (funct3)
    3'd0: res = alt ? (x - y) : (x + y);
    3'd1: res = x << y[4:0];
    3'd2: res = {31'b0, $signed(x) < $signed(y)};
    3'd3: res = {31'b0, x < y};
    3'd4: res = x ^ y;
    3'd5:
    begin
      if (alt)
        res = $signed(x) >>> y[4:0];
      else
        res = x >> y[4:0];
    end
    3'd6: res = x | y;
    default: res = x & y;
  endcase
  return res;
endfunction

function automatic logic branchTaken(input logic [2:0] funct3, input logic [31:0] x,
                                     input logic [31:0] y);
  case (funct3)
    3'd0: return x == y;
    3'd1: return x != y;
    3'd4: return $signed(x) < $signed(y);
    3'd5: return $signed(x) >= $signed(y);
    3'd6: return x < y;
    3'd7: return x >= y;
    default: return 1'b0;
  endcase
endfunction

// ====================
// Instruction model
// ====================

task automatic predict(input riscvPkg::instr_t ins, output riscvPkg::writeBack_t expWb,
                       output logic [31:0] expNext);
  logic [31:0] rs1Val;
  logic [31:0] rs2Val;
  logic [31:0] immI;
  logic [31:0] immB;
  logic [31:0] immJ;
  logic [31:0] target;
  logic        writes;
  rs1Val = readReg(ins.rType.rs1);
  rs2Val = readReg(ins.rType.rs2);
  immI   = {{20{ins.iType.imm[11]}}, ins.iType.imm};
  immB   = {{19{ins.bType.imm12}}, ins.bType.imm12, ins.bType.imm11,
            ins.bType.imm10to5, ins.bType.imm4to1, 1'b0};
  immJ   = {{11{ins.jType.imm20}}, ins.jType.imm20, ins.jType.imm19to12,
            ins.jType.imm11, ins.jType.imm10to1, 1'b0};
  expWb  = '0;
  writes = 1'b1;
  target = modelPc + 32'd4;
  case (ins.rType.opcode)
    riscvPkg::opOp:
      expWb.data = aluModel(ins.rType.funct3, ins.rType.funct7[5], rs1Val, rs2Val);
    riscvPkg::opOpImm:
      expWb.data = aluModel(ins.iType.funct3, (ins.iType.funct3 == 3'd5) && ins.iType.imm[10],
                            rs1Val, immI);
    riscvPkg::opLui:   expWb.data = {ins.uType.imm, 12'h000};
    riscvPkg::opAuipc: expWb.data = modelPc + {ins.uType.imm, 12'h000};
    riscvPkg::opJal:
    begin
      expWb.data = modelPc + 32'd4;
      target     = modelPc + immJ;
    end
    riscvPkg::opJalr:
    begin
      expWb.data = modelPc + 32'd4;
      target     = rs1Val + immI;
    end
    riscvPkg::opBranch:
    begin
      writes = 1'b0;
      if (branchTaken(ins.bType.funct3, rs1Val, rs2Val))
        target = modelPc + immB;
    end
    default: writes = 1'b0;  // Retires as a no-op.
  endcase
  expWb.enable = writes;
  expWb.rd     = writes ? ins.rType.rd : 5'd0;
  expNext      = {target[31:2], 2'b00};
endtask

task automatic retire(input riscvPkg::writeBack_t wb, input logic [31:0] nextPc);
  if (wb.enable && (wb.rd != 5'd0))
    modelRegs[wb.rd] = wb.data;
  modelPc = nextPc;
endtask

// ====================
// Compare tasks
// ====================

task automatic checkWriteBack(input riscvPkg::writeBack_t actual,
                              input riscvPkg::writeBack_t expected);
  // rd and data only matter for an enabled write.
  if ((actual.enable !== expected.enable) || (expected.enable && (actual !== expected)))
  begin
    $display("[FAIL] writeBack at pc %h: expected %h, got %h", modelPc, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "Write-back mismatch.");
  end
endtask

task automatic checkPc(input logic [31:0] actual, input logic [31:0] expected);
  if (actual !== expected)
  begin
    $display("[FAIL] instrAddr: expected %h, got %h", expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "PC mismatch.");
  end
endtask

`endif

/* verification/riscvCoreTb.sv */
module riscvCoreTb;

  localparam int numInstr     = 3000;
  localparam int resetCycles  = 5;
  localparam int marginCycles = 20;
  localparam int clkPeriod    = 100;
  localparam int memWords     = 256;

  logic                         clk = 1'b0;
  logic                         reset;
  logic [aluPkg::dataWidth-1:0] instrAddr;
  riscvPkg::instr_t             instr;
  riscvPkg::writeBack_t         writeBack;

  riscvPkg::instr_t             progMem [0:memWords-1];
  int                           seed;
  riscvPkg::writeBack_t         expWb;
  logic [31:0]                  expNext;

  `include "riscvRefModel.svh"

  always #(clkPeriod/2) clk = ~clk;

  assign instr = progMem[instrAddr[9:2]];  // Combinational fetch that wraps at 1 KB.

  riscvCore riscvCore_i
  (
    .clk       (clk),
    .reset     (reset),
    .instrAddr (instrAddr),
    .instr     (instr),
    .writeBack (writeBack)
  );

  // ====================
  // Program generator
  // ====================

  function automatic riscvPkg::instr_t randomInstr();
    riscvPkg::instr_t ins;
    int               kind;
    int               off;
    ins  = $random(seed);
    kind = $unsigned($random(seed)) % 15;
    case (kind)
      0, 1, 2, 3:
      begin
        ins.rType.opcode = riscvPkg::opOp;
        ins.rType.funct7 = {1'b0, ins.rType.funct7[5] &
                            ((ins.rType.funct3 == 3'd0) || (ins.rType.funct3 == 3'd5)), 5'b0};
      end
      4, 5, 6, 7:
      begin
        ins.iType.opcode = riscvPkg::opOpImm;
        if (ins.iType.funct3 == 3'd1)
          ins.iType.imm[11:5] = 7'h00;
        else if (ins.iType.funct3 == 3'd5)
          ins.iType.imm[11:5] = {1'b0, ins.iType.imm[10], 5'b0};  // SRLI or SRAI.
      end
      8: ins.uType.opcode = riscvPkg::opLui;
      9: ins.uType.opcode = riscvPkg::opAuipc;
      10, 11:
      begin
        off = $unsigned($random(seed)) % 16;
        off = (off == 5) ? 8 : (off - 5) * 4;  // Short hop that is never zero.
        ins.bType.opcode   = riscvPkg::opBranch;
        if (ins.bType.funct3[2:1] == 2'b01)
          ins.bType.funct3[2] = 1'b1;  // Only defined conditions.
        ins.bType.imm12    = off[12];
        ins.bType.imm11    = off[11];
        ins.bType.imm10to5 = off[10:5];
        ins.bType.imm4to1  = off[4:1];
      end
      12:
      begin
        off = ($unsigned($random(seed)) % 32 + 1) * 4;  // Forward only.
        ins.jType.opcode    = riscvPkg::opJal;
        ins.jType.imm20     = off[20];
        ins.jType.imm19to12 = off[19:12];
        ins.jType.imm11     = off[11];
        ins.jType.imm10to1  = off[10:1];
      end
      13:
      begin
        ins.iType.opcode = riscvPkg::opJalr;
        ins.iType.funct3 = 3'd0;
      end
      default:
      begin
        case (ins.rType.rd[1:0])
          2'd0: ins.rType.opcode = 7'b0000011;  // LOAD.
          2'd1: ins.rType.opcode = 7'b0100011;  // STORE.
          2'd2: ins.rType.opcode = 7'b0001111;  // FENCE.
          default: ins.rType.opcode = 7'b1110011;
        endcase
      end
    endcase
    return ins;
  endfunction

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    reset = 1'b1;
    seed  = 77594;
    for (int i = 0; i < memWords; i++)
      progMem[i] = randomInstr();
    progMem[0].uType.opcode = riscvPkg::opLui;  // Word 0 is a write that reset has to mask.
    for (int i = 0; i < riscvPkg::regCount; i++)
      modelRegs[i] = '0;
    modelPc = '0;

    repeat (resetCycles - 1)
    begin
      @(negedge clk);
      checkPc(instrAddr, 32'd0);
      checkWriteBack(writeBack, '0);  // No write while in reset.
    end
    @(posedge clk);
    reset <= 1'b0;

    for (int n = 0; n < numInstr; n++)
    begin
      @(negedge clk);
      predict(progMem[modelPc[9:2]], expWb, expNext);
      checkPc(instrAddr, modelPc);
      checkWriteBack(writeBack, expWb);
      retire(expWb, expNext);
    end

    $display("Simulation PASSED");
    $finish;
  end

  initial
  begin
    #((numInstr + resetCycles + marginCycles) * clkPeriod);
    $display("Watchdog expired, the simulation timed out before all instructions retired.");
    $display("Simulation FAILED");
    $fatal(1, "Timeout.");
  end

endmodule

/* riscvCore.f */
+incdir+verification
source/aluPkg.sv
source/riscvPkg.sv
source/aluRiscv.sv
source/instrDecoder.sv
source/registerFile.sv
source/riscvCore.sv
verification/riscvCoreTb.sv

/* Bender.yml */
package:
  name: riscvCore

sources:
  # Packages first, then the RTL in dependency order.
  - source/aluPkg.sv
  - source/riscvPkg.sv
  - source/aluRiscv.sv
  - source/instrDecoder.sv
  - source/registerFile.sv
  - source/riscvCore.sv

  # Testbench with its included reference model.
  - target: test
    include_dirs:
      - verification
    files:
      - verification/riscvCoreTb.sv
